//--- list.f
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/pipe_reg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/core_top.sv
tests/core_checker.sv
tests/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --timescale 1ns/1ps --top-module core_tb -f list.f

output="$(./obj_dir/Vcore_tb)"
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
    exit 0
fi
exit 1

//--- tests/core_checker.sv
`default_nettype none

module core_checker #(
    parameter int          N_EXP    = 1,
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        sram_ren_i,
    input  logic [31:0] sram_addr_i,
    input  logic        retire_valid_i,
    input  logic [31:0] retire_pc_i,
    input  logic [31:0] retire_instr_i,
    input  logic        retire_wen_i,
    input  logic [4:0]  retire_rd_i,
    input  logic [31:0] retire_data_i,
    input  logic [31:0] exp_pc_i    [N_EXP],
    input  logic [31:0] exp_instr_i [N_EXP],
    input  logic        exp_wen_i   [N_EXP],
    input  logic [4:0]  exp_rd_i    [N_EXP],
    input  logic [31:0] exp_data_i  [N_EXP],
    output logic        done_o,
    output int          retired_o,
    output int          mismatch_cnt_o,
    output int          extra_cnt_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int   idx = 0;
    int   mismatches = 0;
    int   extras = 0;
    logic first_req_seen = 1'b0;

    assign done_o         = (idx >= N_EXP);
    assign retired_o      = idx;
    assign mismatch_cnt_o = mismatches;
    assign extra_cnt_o    = extras;

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] t=%0d ns %s expected %h actual %h",
                     $time, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_retire;
        if (idx < N_EXP) begin
            compare_field("retire_pc_o", exp_pc_i[idx], retire_pc_i);
            compare_field("retire_instr_o", exp_instr_i[idx], retire_instr_i);
            compare_field("retire_wen_o", 32'(exp_wen_i[idx]), 32'(retire_wen_i));
            // rd and data only matter when a register is written
            if (exp_wen_i[idx]) begin
                compare_field("retire_rd_o", 32'(exp_rd_i[idx]), 32'(retire_rd_i));
                compare_field("retire_data_o", exp_data_i[idx], retire_data_i);
            end
            idx++;
        end else if (retire_pc_i !== exp_pc_i[N_EXP-1]) begin
            // the closing jal loops on itself and may retire again
            $display("unexpected retirement at %0d ns: pc %h after the last expected one",
                     $time, retire_pc_i);
            extras++;
        end
    endtask

    // sample mid-cycle, away from the rising edge
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            compare_field("sram_ren_o", 32'd0, 32'(sram_ren_i));
            compare_field("retire_valid_o", 32'd0, 32'(retire_valid_i));
        end else begin
            if (sram_ren_i && !first_req_seen) begin
                first_req_seen = 1'b1;
                compare_field("sram_addr_o", RESET_PC, sram_addr_i);
            end
            if (retire_valid_i) begin
                check_retire();
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/core_tb.sv
`default_nettype none

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RESET_PC       = 32'h0000_0040;
    localparam int          BASE_WORD      = int'(RESET_PC >> 2);
    localparam int          MEM_WORDS      = 64;
    localparam int          PROG_LEN       = 23;
    localparam int          N_EXP          = 20;
    localparam int          MAX_LAT        = 4;
    localparam int          TIMEOUT_CYCLES = PROG_LEN * MAX_LAT + 50;
    localparam int          DRAIN_CYCLES   = 12;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic [31:0] sram_rdata = 32'h0;
    logic        sram_data_valid = 1'b0;
    logic [31:0] sram_addr;
    logic        sram_ren;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_instr;
    logic        retire_wen;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog [PROG_LEN];
    logic [31:0] exp_pc [N_EXP];
    logic [31:0] exp_instr [N_EXP];
    logic        exp_wen [N_EXP];
    logic [4:0]  exp_rd [N_EXP];
    logic [31:0] exp_data [N_EXP];
    int          prog_count = 0;
    int          exp_count = 0;

    logic [31:0] rand_state = 32'h469e;
    logic [31:0] next_rand;
    logic        busy = 1'b0;
    logic [1:0]  wait_cnt = 2'd0;
    logic [31:0] req_addr = 32'h0;
    int          cycles = 0;
    int          missing = 0;

    logic        chk_done;
    int          retired;
    int          mismatch_cnt;
    int          extra_cnt;

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'h41c6_4e6d + 32'h0000_3039;
    endfunction

    function automatic logic [31:0] alu_reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                                 input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input int rd, input logic [19:0] upper);
        return {upper, 5'(rd), 7'b0110111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int offset);
        logic [12:0] off;
        off = 13'(offset);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, input int offset);
        logic [20:0] off;
        off = 21'(offset);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic put_instr(input logic [31:0] word);
        prog[prog_count] = word;
        prog_count++;
    endtask

    // the retired word is the program entry at that pc
    task automatic expect_retire(input logic [31:0] pc, input logic wen, input int rd,
                                 input logic [31:0] data);
        exp_pc[exp_count]    = pc;
        exp_instr[exp_count] = prog[(pc - RESET_PC) >> 2];
        exp_wen[exp_count]   = wen;
        exp_rd[exp_count]    = 5'(rd);
        exp_data[exp_count]  = data;
        exp_count++;
    endtask

    core_top #(
        .RESET_PC          (RESET_PC)
    ) core_top_i (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .sram_rdata_i      (sram_rdata),
        .sram_data_valid_i (sram_data_valid),
        .sram_addr_o       (sram_addr),
        .sram_ren_o        (sram_ren),
        .retire_valid_o    (retire_valid),
        .retire_pc_o       (retire_pc),
        .retire_instr_o    (retire_instr),
        .retire_wen_o      (retire_wen),
        .retire_rd_o       (retire_rd),
        .retire_data_o     (retire_data)
    );

    core_checker #(
        .N_EXP          (N_EXP),
        .RESET_PC       (RESET_PC)
    ) core_checker_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .sram_ren_i     (sram_ren),
        .sram_addr_i    (sram_addr),
        .retire_valid_i (retire_valid),
        .retire_pc_i    (retire_pc),
        .retire_instr_i (retire_instr),
        .retire_wen_i   (retire_wen),
        .retire_rd_i    (retire_rd),
        .retire_data_i  (retire_data),
        .exp_pc_i       (exp_pc),
        .exp_instr_i    (exp_instr),
        .exp_wen_i      (exp_wen),
        .exp_rd_i       (exp_rd),
        .exp_data_i     (exp_data),
        .done_o         (chk_done),
        .retired_o      (retired),
        .mismatch_cnt_o (mismatch_cnt),
        .extra_cnt_o    (extra_cnt)
    );

    assign next_rand = lcg_next(rand_state);

    // instruction memory, latency of 1 to MAX_LAT cycles per request
    always @(posedge clk) begin
        if (!arst_n) begin
            sram_data_valid <= 1'b0;
            busy            <= 1'b0;
        end else begin
            sram_data_valid <= 1'b0;
            if (busy && wait_cnt == 2'd0) begin
                sram_data_valid <= 1'b1;
                sram_rdata      <= mem[req_addr[7:2]];
                busy            <= 1'b0;
            end else if (busy) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            if (sram_ren) begin
                rand_state <= next_rand;
                if (next_rand[17:16] == 2'd0) begin
                    sram_data_valid <= 1'b1;
                    sram_rdata      <= mem[sram_addr[7:2]];
                end else begin
                    busy     <= 1'b1;
                    req_addr <= sram_addr;
                    wait_cnt <= next_rand[17:16] - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        // x1 = 5, x2 = -3, x3 = 0x12345000
        put_instr(addi_word(1, 0, 5));
        put_instr(addi_word(2, 0, -3));
        put_instr(lui_word(3, 20'h12345));
        // add, sub, and, or, xor, slt, slt
        put_instr(alu_reg_word(7'h00, 3'b000, 4, 1, 2));
        put_instr(alu_reg_word(7'h20, 3'b000, 5, 1, 2));
        put_instr(alu_reg_word(7'h00, 3'b111, 6, 2, 1));
        put_instr(alu_reg_word(7'h00, 3'b110, 7, 1, 3));
        put_instr(alu_reg_word(7'h00, 3'b100, 8, 3, 2));
        put_instr(alu_reg_word(7'h00, 3'b010, 9, 2, 1));
        put_instr(alu_reg_word(7'h00, 3'b010, 10, 1, 2));
        // dependent chain
        put_instr(addi_word(11, 1, 1));
        put_instr(alu_reg_word(7'h00, 3'b000, 12, 11, 11));
        put_instr(alu_reg_word(7'h20, 3'b000, 13, 12, 11));
        // write to x0, then read it straight back
        put_instr(addi_word(0, 1, 7));
        put_instr(alu_reg_word(7'h00, 3'b000, 14, 0, 1));
        // bne not taken, beq taken over two, jal over one
        put_instr(branch_word(3'b001, 1, 1, 8));
        put_instr(branch_word(3'b000, 13, 11, 12));
        put_instr(addi_word(20, 0, 1));
        put_instr(addi_word(21, 0, 1));
        put_instr(jal_word(15, 8));
        put_instr(addi_word(22, 0, 1));
        put_instr(alu_reg_word(7'h00, 3'b000, 16, 15, 0));
        // halt loop
        put_instr(jal_word(0, 0));

        expect_retire(32'h40, 1'b1, 1, 32'h0000_0005);
        expect_retire(32'h44, 1'b1, 2, 32'hffff_fffd);
        expect_retire(32'h48, 1'b1, 3, 32'h1234_5000);
        expect_retire(32'h4c, 1'b1, 4, 32'h0000_0002);
        expect_retire(32'h50, 1'b1, 5, 32'h0000_0008);
        expect_retire(32'h54, 1'b1, 6, 32'h0000_0005);
        expect_retire(32'h58, 1'b1, 7, 32'h1234_5005);
        expect_retire(32'h5c, 1'b1, 8, 32'hedcb_affd);
        expect_retire(32'h60, 1'b1, 9, 32'h0000_0001);
        expect_retire(32'h64, 1'b1, 10, 32'h0000_0000);
        expect_retire(32'h68, 1'b1, 11, 32'h0000_0006);
        expect_retire(32'h6c, 1'b1, 12, 32'h0000_000c);
        expect_retire(32'h70, 1'b1, 13, 32'h0000_0006);
        expect_retire(32'h74, 1'b1, 0, 32'h0000_000c);
        expect_retire(32'h78, 1'b1, 14, 32'h0000_0005);
        expect_retire(32'h7c, 1'b0, 0, 32'h0);
        expect_retire(32'h80, 1'b0, 0, 32'h0);
        expect_retire(32'h8c, 1'b1, 15, 32'h0000_0090);
        expect_retire(32'h94, 1'b1, 16, 32'h0000_0090);
        expect_retire(32'h98, 1'b1, 0, 32'h0000_009c);

        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = 32'hbad0_0000 | (a * 4);
        end
        for (int k = 0; k < PROG_LEN; k++) begin
            mem[BASE_WORD + k] = prog[k];
        end

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        while (!chk_done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (chk_done) begin
            // let the halt loop spin to catch stray retirements
            repeat (DRAIN_CYCLES) @(posedge clk);
        end else begin
            missing = N_EXP - retired;
            $display("timeout after %0d cycles: %0d expected retirements never appeared",
                     cycles, missing);
        end

        $display("errors: mismatch %0d, extra %0d, missing %0d",
                 mismatch_cnt, extra_cnt, missing);
        if (mismatch_cnt + extra_cnt + missing == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`default_nettype none

module core_top #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                              clk_i,
    input  wire                              arst_n_i,

    input  wire  [rv_isa_pkg::XLEN-1:0]      sram_rdata_i,
    input  wire                              sram_data_valid_i,
    output logic [rv_isa_pkg::XLEN-1:0]      sram_addr_o,
    output logic                             sram_ren_o,

    output logic                             retire_valid_o,
    output logic [rv_isa_pkg::XLEN-1:0]      retire_pc_o,
    output logic [31:0]                      retire_instr_o,
    output logic                             retire_wen_o,
    output logic [4:0]                       retire_rd_o,
    output logic [rv_isa_pkg::XLEN-1:0]      retire_data_o
);

    pipe_pkg::if_id_t            if_id_d;
    pipe_pkg::if_id_t            if_id_q;
    pipe_pkg::id_ex_t            id_ex_d;
    pipe_pkg::id_ex_t            id_ex_q;
    pipe_pkg::ex_wb_t            ex_wb_d;
    pipe_pkg::ex_wb_t            ex_wb_q;
    logic                        is_jump;
    logic [rv_isa_pkg::XLEN-1:0] jump_target;

    fetch_stage #(
        .RESET_PC          (RESET_PC)
    ) fetch_stage_u (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .is_jump_i         (is_jump),
        .jump_target_i     (jump_target),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .sram_addr_o       (sram_addr_o),
        .sram_ren_o        (sram_ren_o),
        .if_id_o           (if_id_d)
    );

    pipe_reg #(
        .payload_t (pipe_pkg::if_id_t)
    ) id_reg (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .flush_i   (is_jump),
        .d_i       (if_id_d),
        .q_o       (if_id_q)
    );

    decode_stage decode_stage_u (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .if_id_i   (if_id_q),
        .wb_i      (ex_wb_q),
        .id_ex_o   (id_ex_d)
    );

    pipe_reg #(
        .payload_t (pipe_pkg::id_ex_t)
    ) ex_reg (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .flush_i   (is_jump),
        .d_i       (id_ex_d),
        .q_o       (id_ex_q)
    );

    execute_stage execute_stage_u (
        .id_ex_i       (id_ex_q),
        .wb_i          (ex_wb_q),
        .ex_wb_o       (ex_wb_d),
        .is_jump_o     (is_jump),
        .jump_target_o (jump_target)
    );

    // the jump itself retires, so writeback is never flushed
    pipe_reg #(
        .payload_t (pipe_pkg::ex_wb_t)
    ) wb_reg (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .flush_i   (1'b0),
        .d_i       (ex_wb_d),
        .q_o       (ex_wb_q)
    );

    assign retire_valid_o = ex_wb_q.valid;
    assign retire_pc_o    = ex_wb_q.pc;
    assign retire_instr_o = ex_wb_q.instr;
    assign retire_wen_o   = ex_wb_q.wen;
    assign retire_rd_o    = ex_wb_q.rd;
    assign retire_data_o  = ex_wb_q.result;

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                      clk_i,
    input  wire                      arst_n_i,
    input  wire  pipe_pkg::if_id_t   if_id_i,
    input  wire  pipe_pkg::ex_wb_t   wb_i,
    output pipe_pkg::id_ex_t         id_ex_o
);

    logic [rv_isa_pkg::XLEN-1:0] regs [32];
    logic                        wr_en;
    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [4:0]                  rs1_idx;
    logic [4:0]                  rs2_idx;
    logic [31:0]                 instr;
    logic [rv_isa_pkg::XLEN-1:0] imm_i;
    logic [rv_isa_pkg::XLEN-1:0] imm_u;
    logic [rv_isa_pkg::XLEN-1:0] imm_b;
    logic [rv_isa_pkg::XLEN-1:0] imm_j;

    assign instr   = if_id_i.instr;
    assign opcode  = instr[6:0];
    assign funct3  = instr[rv_isa_pkg::F3_LSB +: 3];
    assign funct7  = instr[rv_isa_pkg::F7_LSB +: 7];
    assign rs1_idx = instr[rv_isa_pkg::RS1_LSB +: 5];
    assign rs2_idx = instr[rv_isa_pkg::RS2_LSB +: 5];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // x0 is never written
    assign wr_en = wb_i.valid && wb_i.wen && (wb_i.rd != 5'd0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.result;
        end
    end

    always_comb begin
        id_ex_o         = '0;
        id_ex_o.valid   = if_id_i.valid;
        id_ex_o.pc      = if_id_i.pc;
        id_ex_o.instr   = instr;
        id_ex_o.rs1_idx = rs1_idx;
        id_ex_o.rs2_idx = rs2_idx;
        id_ex_o.rd      = instr[rv_isa_pkg::RD_LSB +: 5];
        id_ex_o.alu_op  = rv_isa_pkg::ALU_ADD;

        // write-through of the value retiring this cycle
        id_ex_o.rs1_val = (wr_en && wb_i.rd == rs1_idx) ? wb_i.result : regs[rs1_idx];
        id_ex_o.rs2_val = (wr_en && wb_i.rd == rs2_idx) ? wb_i.result : regs[rs2_idx];

        case (opcode)
            rv_isa_pkg::OP_REG: begin
                id_ex_o.wen = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        id_ex_o.alu_op = (funct7 == rv_isa_pkg::F7_SUB) ?
                                         rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
                    end
                    rv_isa_pkg::F3_SLT: id_ex_o.alu_op = rv_isa_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: id_ex_o.alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:  id_ex_o.alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: id_ex_o.alu_op = rv_isa_pkg::ALU_AND;
                    default:            id_ex_o.wen    = 1'b0;
                endcase
            end
            rv_isa_pkg::OP_IMM: begin
                // addi only
                id_ex_o.wen      = (funct3 == rv_isa_pkg::F3_ADD_SUB);
                id_ex_o.src2_imm = 1'b1;
                id_ex_o.imm      = imm_i;
            end
            rv_isa_pkg::OP_LUI: begin
                id_ex_o.wen      = 1'b1;
                id_ex_o.src2_imm = 1'b1;
                id_ex_o.imm      = imm_u;
                id_ex_o.alu_op   = rv_isa_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OP_BRANCH: begin
                id_ex_o.is_branch = (funct3 == rv_isa_pkg::F3_BEQ) ||
                                    (funct3 == rv_isa_pkg::F3_BNE);
                id_ex_o.br_ne     = (funct3 == rv_isa_pkg::F3_BNE);
                id_ex_o.imm       = imm_b;
            end
            rv_isa_pkg::OP_JAL: begin
                id_ex_o.is_jal = 1'b1;
                id_ex_o.wen    = 1'b1;
                id_ex_o.imm    = imm_j;
            end
            // unknown opcodes retire without a write
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire  pipe_pkg::id_ex_t           id_ex_i,
    input  wire  pipe_pkg::ex_wb_t           wb_i,
    output pipe_pkg::ex_wb_t                 ex_wb_o,
    output logic                             is_jump_o,
    output logic [rv_isa_pkg::XLEN-1:0]      jump_target_o
);

    logic [rv_isa_pkg::XLEN-1:0] op_a;
    logic [rv_isa_pkg::XLEN-1:0] op_b;
    logic [rv_isa_pkg::XLEN-1:0] src_b;
    logic [rv_isa_pkg::XLEN-1:0] alu_res;
    logic                        fwd_ok;
    logic                        taken;

    // writeback result bypasses the stale operand
    assign fwd_ok = wb_i.valid && wb_i.wen && (wb_i.rd != 5'd0);
    assign op_a   = (fwd_ok && wb_i.rd == id_ex_i.rs1_idx) ? wb_i.result : id_ex_i.rs1_val;
    assign op_b   = (fwd_ok && wb_i.rd == id_ex_i.rs2_idx) ? wb_i.result : id_ex_i.rs2_val;
    assign src_b  = id_ex_i.src2_imm ? id_ex_i.imm : op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_isa_pkg::ALU_ADD:    alu_res = op_a + src_b;
            rv_isa_pkg::ALU_SUB:    alu_res = op_a - src_b;
            rv_isa_pkg::ALU_AND:    alu_res = op_a & src_b;
            rv_isa_pkg::ALU_OR:     alu_res = op_a | src_b;
            rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ src_b;
            rv_isa_pkg::ALU_SLT: begin
                alu_res = {{(rv_isa_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            end
            rv_isa_pkg::ALU_PASS_B: alu_res = src_b;
            default:                alu_res = '0;
        endcase
    end

    // beq on equal, bne on not equal
    assign taken = id_ex_i.is_branch && ((op_a == op_b) != id_ex_i.br_ne);

    assign is_jump_o     = id_ex_i.valid && (id_ex_i.is_jal || taken);
    assign jump_target_o = id_ex_i.pc + id_ex_i.imm;

    assign ex_wb_o.valid  = id_ex_i.valid;
    assign ex_wb_o.pc     = id_ex_i.pc;
    assign ex_wb_o.instr  = id_ex_i.instr;
    assign ex_wb_o.wen    = id_ex_i.wen;
    assign ex_wb_o.rd     = id_ex_i.rd;
    // link address for jal
    assign ex_wb_o.result = id_ex_i.is_jal ? id_ex_i.pc + 4 : alu_res;

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

module fetch_stage #(
    parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                              clk_i,
    input  wire                              arst_n_i,
    input  wire                              is_jump_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]      jump_target_i,
    input  wire  [rv_isa_pkg::XLEN-1:0]      sram_rdata_i,
    input  wire                              sram_data_valid_i,
    output logic [rv_isa_pkg::XLEN-1:0]      sram_addr_o,
    output logic                             sram_ren_o,
    output pipe_pkg::if_id_t                 if_id_o
);

    logic [rv_isa_pkg::XLEN-1:0] pc_q;
    logic                        outstanding_q;
    logic                        drop_q;
    logic                        issue;
    logic                        accept;

    // next request may go out once the current one is answered
    assign issue  = !outstanding_q || sram_data_valid_i;
    assign accept = sram_data_valid_i && !drop_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q          <= RESET_PC;
            outstanding_q <= 1'b0;
            drop_q        <= 1'b0;
            sram_ren_o    <= 1'b0;
        end else begin
            sram_ren_o    <= issue;
            outstanding_q <= issue || (outstanding_q && !sram_data_valid_i);
            if (sram_data_valid_i) begin
                drop_q <= 1'b0;
            end
            // response still in flight belongs to the wrong path
            if (is_jump_i && outstanding_q && !sram_data_valid_i) begin
                drop_q <= 1'b1;
            end
            if (is_jump_i) begin
                pc_q <= jump_target_i;
            end else if (accept) begin
                pc_q <= pc_q + 4;
            end
        end
    end

    assign sram_addr_o = pc_q;

    // anything but an accepted response is a bubble
    assign if_id_o.valid = accept;
    assign if_id_o.pc    = pc_q;
    assign if_id_o.instr = accept ? sram_rdata_i : rv_isa_pkg::NOP_INSTR;

endmodule

`default_nettype wire

//--- verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef struct packed {
        logic                            valid;
        logic [rv_isa_pkg::XLEN-1:0]     pc;
        logic [31:0]                     instr;
    } if_id_t;

    typedef struct packed {
        logic                            valid;
        logic [rv_isa_pkg::XLEN-1:0]     pc;
        logic [31:0]                     instr;
        logic [4:0]                      rs1_idx;
        logic [4:0]                      rs2_idx;
        logic [rv_isa_pkg::XLEN-1:0]     rs1_val;
        logic [rv_isa_pkg::XLEN-1:0]     rs2_val;
        logic [rv_isa_pkg::XLEN-1:0]     imm;
        rv_isa_pkg::alu_op_e             alu_op;
        logic                            src2_imm;
        logic                            is_branch;
        // set for bne, clear for beq
        logic                            br_ne;
        logic                            is_jal;
        logic                            wen;
        logic [4:0]                      rd;
    } id_ex_t;

    typedef struct packed {
        logic                            valid;
        logic [rv_isa_pkg::XLEN-1:0]     pc;
        logic [31:0]                     instr;
        logic                            wen;
        logic [4:0]                      rd;
        logic [rv_isa_pkg::XLEN-1:0]     result;
    } ex_wb_t;

endpackage

`default_nettype wire

//--- verilog/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire              clk_i,
    input  wire              arst_n_i,
    input  wire              flush_i,
    input  wire  payload_t   d_i,
    output payload_t         q_o
);

    // zero payload carries valid = 0
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    // field positions within a 32-bit instruction
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

endpackage

`default_nettype wire
